// ==== source/accel_core_pkg.sv ====
package accel_core_pkg;

    // Pairs per job
    localparam int VEC_LEN = 4;

    // Job buffers, also the load credits upstream holds after reset
    localparam int NUM_BUFS = 3;

    // Result slots downstream grants after reset
    localparam int RES_CREDITS = 2;

    typedef logic signed [7:0] t_act;
    typedef logic signed [7:0] t_wgt;
    typedef logic [5:0] t_tag;

    // Four products of magnitude up to 2^14 need 17 bits plus sign
    typedef logic signed [17:0] t_sum;

    // Pair position inside one job
    typedef logic [1:0] t_addr;

    // Buffer number, 0 to NUM_BUFS-1
    typedef logic [1:0] t_buf_idx;

    // Result credit counter
    typedef logic [2:0] t_credit;

    typedef enum logic [1:0] {
        FREE,
        W1,
        W2,
        W3
    } t_buffer_sel;

endpackage

// ==== source/accel_ifs.sv ====
`timescale 1ns/100ps

// Read port from a MAC unit into the job buffer bank
interface buf_rd_if import accel_core_pkg::*; ();
    t_buffer_sel sel;
    t_addr       addr;
    t_act        act;
    t_wgt        wgt;
    t_tag        tag;

    modport bank (input sel, input addr, output act, output wgt, output tag);
    modport mac (output sel, output addr, input act, input wgt, input tag);
endinterface

// Finished result waiting in a MAC unit
interface mac_res_if import accel_core_pkg::*; ();
    logic valid;
    t_tag tag;
    t_sum sum;
    logic take;

    modport mac (output valid, output tag, output sum, input take);
    modport sender (input valid, input tag, input sum, output take);
endinterface

// ==== source/job_buffer_bank.sv ====
`timescale 1ns/100ps

module job_buffer_bank import accel_core_pkg::*; (
    input  logic                Clock,
    input  logic                rst,
    input  logic                load_valid,
    input  t_act                load_act,
    input  t_wgt                load_wgt,
    input  t_tag                load_tag,
    buf_rd_if.bank              rd_a,
    buf_rd_if.bank              rd_b,
    output logic [NUM_BUFS-1:0] filled,
    input  logic [NUM_BUFS-1:0] release_buf,
    output logic                load_credit
);

    t_act act_mem [NUM_BUFS][VEC_LEN];
    t_wgt wgt_mem [NUM_BUFS][VEC_LEN];
    t_tag tag_mem [NUM_BUFS];

    t_addr    word_cnt;
    t_buf_idx wr_idx;
    t_buf_idx free_idx;
    t_buf_idx cur_idx;
    t_buf_idx rd_a_idx;
    t_buf_idx rd_b_idx;
    logic     last_word;

    function automatic t_buf_idx sel_to_idx(t_buffer_sel s);
        case (s)
            W2:      return t_buf_idx'(1);
            W3:      return t_buf_idx'(2);
            default: return t_buf_idx'(0);
        endcase
    endfunction

    // Lowest numbered buffer without a complete job in it
    always_comb begin
        free_idx = '0;
        for (int i = NUM_BUFS - 1; i >= 0; i--) begin
            if (!filled[i]) begin
                free_idx = t_buf_idx'(i);
            end
        end
    end

    // A new job picks its buffer on the first word, later words follow wr_idx
    assign cur_idx   = (word_cnt == '0) ? free_idx : wr_idx;
    assign last_word = load_valid && (word_cnt == t_addr'(VEC_LEN - 1));

    always_ff @(posedge Clock) begin
        if (load_valid) begin
            act_mem[cur_idx][word_cnt] <= load_act;
            wgt_mem[cur_idx][word_cnt] <= load_wgt;
            if (word_cnt == '0) begin
                tag_mem[cur_idx] <= load_tag;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            word_cnt    <= '0;
            wr_idx      <= '0;
            filled      <= '0;
            load_credit <= 1'b0;
        end else begin
            // At most one buffer is released per cycle
            load_credit <= |release_buf;
            filled      <= (filled & ~release_buf) |
                           (last_word ? (NUM_BUFS'(1) << cur_idx) : '0);
            if (load_valid) begin
                word_cnt <= last_word ? '0 : word_cnt + t_addr'(1);
                if (word_cnt == '0) begin
                    wr_idx <= free_idx;
                end
            end
        end
    end

    assign rd_a_idx = sel_to_idx(rd_a.sel);
    assign rd_b_idx = sel_to_idx(rd_b.sel);

    assign rd_a.act = act_mem[rd_a_idx][rd_a.addr];
    assign rd_a.wgt = wgt_mem[rd_a_idx][rd_a.addr];
    assign rd_a.tag = tag_mem[rd_a_idx];

    assign rd_b.act = act_mem[rd_b_idx][rd_b.addr];
    assign rd_b.wgt = wgt_mem[rd_b_idx][rd_b.addr];
    assign rd_b.tag = tag_mem[rd_b_idx];

endmodule

// ==== source/mul_controller.sv ====
`timescale 1ns/100ps

module mul_controller import accel_core_pkg::*; (
    input  logic                Clock,
    input  logic                rst,
    input  logic [NUM_BUFS-1:0] filled,
    output logic [NUM_BUFS-1:0] release_buf,
    output logic                start_a,
    output t_buffer_sel         sel_a,
    input  logic                done_a,
    output logic                start_b,
    output t_buffer_sel         sel_b,
    input  logic                done_b
);

    logic [NUM_BUFS-1:0] avail;
    logic [NUM_BUFS-1:0] rel_next;
    t_buffer_sel         next_a;
    t_buffer_sel         next_b;
    logic                go_a;
    logic                go_b;

    function automatic t_buffer_sel buf_of(int i);
        return t_buffer_sel'(2'(i + 1));
    endfunction

    always_comb begin
        // A buffer released last cycle still shows filled for one more cycle
        avail    = filled & ~release_buf;
        next_a   = sel_a;
        next_b   = sel_b;
        go_a     = 1'b0;
        go_b     = 1'b0;
        rel_next = '0;

        for (int i = 0; i < NUM_BUFS; i++) begin
            if (done_a && sel_a == buf_of(i)) begin
                rel_next[i] = 1'b1;
            end
            if (done_b && sel_b == buf_of(i)) begin
                rel_next[i] = 1'b1;
            end
        end
        if (done_a) begin
            next_a = FREE;
        end
        if (done_b) begin
            next_b = FREE;
        end

        // Unit a chooses first, unit b skips whatever a just took
        if (sel_a == FREE && !done_a) begin
            for (int i = 0; i < NUM_BUFS; i++) begin
                if (!go_a && avail[i] && sel_b != buf_of(i)) begin
                    next_a = buf_of(i);
                    go_a   = 1'b1;
                end
            end
        end
        if (sel_b == FREE && !done_b) begin
            for (int i = 0; i < NUM_BUFS; i++) begin
                if (!go_b && avail[i] && sel_a != buf_of(i) && next_a != buf_of(i)) begin
                    next_b = buf_of(i);
                    go_b   = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            sel_a       <= FREE;
            sel_b       <= FREE;
            start_a     <= 1'b0;
            start_b     <= 1'b0;
            release_buf <= '0;
        end else begin
            sel_a       <= next_a;
            sel_b       <= next_b;
            start_a     <= go_a;
            start_b     <= go_b;
            release_buf <= rel_next;
        end
    end

endmodule

// ==== source/mac_unit.sv ====
`timescale 1ns/100ps

module mac_unit import accel_core_pkg::*; (
    input  logic        Clock,
    input  logic        rst,
    input  logic        start,
    input  t_buffer_sel sel,
    output logic        done,
    buf_rd_if.mac       rd,
    mac_res_if.mac      res
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        HOLD
    } t_mac_state;

    t_mac_state  state;
    t_buffer_sel cur_sel;
    t_addr       addr;
    t_sum        acc;
    t_tag        tag_q;
    logic signed [$bits(t_act)+$bits(t_wgt)-1:0] prod;
    logic        last_pair;

    assign rd.sel    = cur_sel;
    assign rd.addr   = addr;
    assign prod      = rd.act * rd.wgt;
    assign last_pair = (state == RUN) && (addr == t_addr'(VEC_LEN - 1));

    assign res.valid = (state == HOLD);
    assign res.tag   = tag_q;
    assign res.sum   = acc;

    // Pulses in the cycle the sender accepts the result
    assign done = (state == HOLD) && res.take;

    always_ff @(posedge Clock) begin
        if (rst) begin
            state   <= IDLE;
            cur_sel <= FREE;
            addr    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state   <= RUN;
                        cur_sel <= sel;
                        addr    <= '0;
                    end
                end
                RUN: begin
                    addr <= addr + t_addr'(1);
                    if (last_pair) begin
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    if (res.take) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (start) begin
            acc <= '0;
        end else if (state == RUN) begin
            acc <= acc + t_sum'(prod);
        end
        if (last_pair) begin
            tag_q <= rd.tag;
        end
    end

endmodule

// ==== source/result_sender.sv ====
`timescale 1ns/100ps

module result_sender import accel_core_pkg::*; (
    input  logic       Clock,
    input  logic       rst,
    mac_res_if.sender  res_a,
    mac_res_if.sender  res_b,
    input  logic       res_credit,
    output logic       res_valid,
    output t_tag       res_tag,
    output t_sum       res_sum
);

    t_credit credits;
    logic    prio_b;
    logic    can_send;
    logic    pick_a;
    logic    pick_b;
    logic    sent;

    // Round robin, prio_b set after unit a was served
    assign can_send = (credits != '0);
    assign pick_a   = can_send && res_a.valid && (!res_b.valid || !prio_b);
    assign pick_b   = can_send && res_b.valid && !pick_a;
    assign sent     = pick_a || pick_b;

    assign res_a.take = pick_a;
    assign res_b.take = pick_b;

    always_ff @(posedge Clock) begin
        if (rst) begin
            credits   <= t_credit'(RES_CREDITS);
            res_valid <= 1'b0;
            prio_b    <= 1'b0;
        end else begin
            credits   <= credits + t_credit'(res_credit) - t_credit'(sent);
            res_valid <= sent;
            if (pick_a) begin
                prio_b <= 1'b1;
            end else if (pick_b) begin
                prio_b <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (pick_a) begin
            res_tag <= res_a.tag;
            res_sum <= res_a.sum;
        end else if (pick_b) begin
            res_tag <= res_b.tag;
            res_sum <= res_b.sum;
        end
    end

endmodule

// ==== source/accel_core_top.sv ====
`timescale 1ns/100ps

module accel_core_top import accel_core_pkg::*; (
    input  logic Clock,
    input  logic rst,
    input  logic load_valid,
    input  t_act load_act,
    input  t_wgt load_wgt,
    input  t_tag load_tag,
    output logic load_credit,
    output logic res_valid,
    output t_tag res_tag,
    output t_sum res_sum,
    input  logic res_credit
);

    logic [NUM_BUFS-1:0] filled;
    logic [NUM_BUFS-1:0] release_buf;
    logic                start_a;
    logic                start_b;
    t_buffer_sel         sel_a;
    t_buffer_sel         sel_b;
    logic                done_a;
    logic                done_b;

    buf_rd_if  rd_a ();
    buf_rd_if  rd_b ();
    mac_res_if res_a ();
    mac_res_if res_b ();

    job_buffer_bank i_bank (
        .Clock       (Clock),
        .rst         (rst),
        .load_valid  (load_valid),
        .load_act    (load_act),
        .load_wgt    (load_wgt),
        .load_tag    (load_tag),
        .rd_a        (rd_a.bank),
        .rd_b        (rd_b.bank),
        .filled      (filled),
        .release_buf (release_buf),
        .load_credit (load_credit)
    );

    mul_controller i_ctrl (
        .Clock       (Clock),
        .rst         (rst),
        .filled      (filled),
        .release_buf (release_buf),
        .start_a     (start_a),
        .sel_a       (sel_a),
        .done_a      (done_a),
        .start_b     (start_b),
        .sel_b       (sel_b),
        .done_b      (done_b)
    );

    mac_unit i_mac_a (
        .Clock (Clock),
        .rst   (rst),
        .start (start_a),
        .sel   (sel_a),
        .done  (done_a),
        .rd    (rd_a.mac),
        .res   (res_a.mac)
    );

    mac_unit i_mac_b (
        .Clock (Clock),
        .rst   (rst),
        .start (start_b),
        .sel   (sel_b),
        .done  (done_b),
        .rd    (rd_b.mac),
        .res   (res_b.mac)
    );

    result_sender i_sender (
        .Clock      (Clock),
        .rst        (rst),
        .res_a      (res_a.sender),
        .res_b      (res_b.sender),
        .res_credit (res_credit),
        .res_valid  (res_valid),
        .res_tag    (res_tag),
        .res_sum    (res_sum)
    );

endmodule

// ==== test/accel_core_tb.sv ====
`timescale 1ns/100ps

module accel_core_tb import accel_core_pkg::*; ();

    localparam int NUM_JOBS   = 48;
    localparam int MAX_CYCLES = NUM_JOBS * 60;
    localparam int BP_START   = 150;
    localparam int BP_CYCLES  = 200;

    logic Clock;
    logic rst;
    logic load_valid;
    t_act load_act;
    t_wgt load_wgt;
    t_tag load_tag;
    logic load_credit;
    logic res_valid;
    t_tag res_tag;
    t_sum res_sum;
    logic res_credit;

    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          cycle;
    logic        timed_out;

    // Reference model, indexed by tag
    t_sum exp_sum [64];
    logic exp_valid [64];
    logic seen [64];

    int ld_credits;
    int ld_pulses;
    int res_granted;
    int received;
    int credit_due [$];

    // Upstream job state
    int job_idx;
    int word_idx;
    int gap;
    int job_sum;

    accel_core_top i_dut (
        .Clock       (Clock),
        .rst         (rst),
        .load_valid  (load_valid),
        .load_act    (load_act),
        .load_wgt    (load_wgt),
        .load_tag    (load_tag),
        .load_credit (load_credit),
        .res_valid   (res_valid),
        .res_tag     (res_tag),
        .res_sum     (res_sum),
        .res_credit  (res_credit)
    );

    always #2 Clock = ~Clock;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_sum(input string name, input t_sum got, input t_sum exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input t_tag got, input t_tag exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_idle(input string when);
        checks++;
        if (res_valid !== 1'b0) begin
            errors++;
            $display("[FAIL] res_valid %s got 0x%h expected 0x0", when, res_valid);
        end
        if (load_credit !== 1'b0) begin
            errors++;
            $display("[FAIL] load_credit %s got 0x%h expected 0x0", when, load_credit);
        end
    endtask

    task automatic watch_load_credit();
        if (load_credit) begin
            ld_credits++;
            ld_pulses++;
            if (ld_credits > NUM_BUFS) begin
                errors++;
                $display("More load credits returned than buffers at cycle %0d", cycle);
            end
        end
    endtask

    task automatic watch_results();
        int open_cnt;
        int open_tag;
        if (res_valid) begin
            if (res_granted == 0) begin
                errors++;
                $display("Result sent with no result credit granted at cycle %0d", cycle);
            end else begin
                res_granted--;
            end
            // Downstream frees the slot after a random delay
            credit_due.push_back(cycle + 1 + int'(next_rand() % 8));
            // With one loaded job outstanding, only its tag can come back
            open_cnt = 0;
            open_tag = 0;
            for (int t = 0; t < job_idx; t++) begin
                if (!seen[t]) begin
                    open_cnt++;
                    open_tag = t;
                end
            end
            if (open_cnt == 1) begin
                check_tag("res_tag", res_tag, t_tag'(open_tag));
            end
            if (!exp_valid[res_tag]) begin
                errors++;
                $display("Unknown tag %0d received at cycle %0d", res_tag, cycle);
            end else if (seen[res_tag]) begin
                errors++;
                $display("Tag %0d received twice, again at cycle %0d", res_tag, cycle);
            end else begin
                seen[res_tag] = 1'b1;
                received++;
                check_sum($sformatf("res_sum for tag %0d", res_tag), res_sum, exp_sum[res_tag]);
            end
        end
    endtask

    task automatic return_credit();
        logic withhold;
        withhold   = (cycle >= BP_START) && (cycle < BP_START + BP_CYCLES);
        res_credit = 1'b0;
        if (!withhold && credit_due.size() > 0) begin
            if (credit_due[0] <= cycle) begin
                void'(credit_due.pop_front());
                res_credit = 1'b1;
                res_granted++;
            end
        end
    endtask

    task automatic drive_load();
        logic [31:0] r;
        load_valid = 1'b0;
        if (gap > 0) begin
            gap--;
        end else if (job_idx < NUM_JOBS && (word_idx != 0 || ld_credits > 0)) begin
            if (word_idx == 0) begin
                ld_credits--;
                job_sum = 0;
            end
            r          = next_rand();
            load_valid = 1'b1;
            load_act   = t_act'(r[7:0]);
            load_wgt   = t_wgt'(r[15:8]);
            load_tag   = t_tag'(job_idx);
            job_sum    = job_sum + int'(load_act) * int'(load_wgt);
            gap        = int'(r[17:16]);
            word_idx++;
            if (word_idx == VEC_LEN) begin
                exp_sum[job_idx]   = t_sum'(job_sum);
                exp_valid[job_idx] = 1'b1;
                word_idx           = 0;
                job_idx++;
            end
        end
    endtask

    // One clock cycle, everything sampled and driven on the falling edge
    task automatic step();
        watch_load_credit();
        watch_results();
        return_credit();
        drive_load();
        @(negedge Clock);
        cycle++;
        if (cycle >= MAX_CYCLES) begin
            timed_out = 1'b1;
        end
    endtask

    initial begin
        Clock       = 1'b0;
        rst         = 1'b1;
        load_valid  = 1'b0;
        load_act    = '0;
        load_wgt    = '0;
        load_tag    = '0;
        res_credit  = 1'b0;
        rng_state   = 32'd1;
        errors      = 0;
        checks      = 0;
        cycle       = 0;
        timed_out   = 1'b0;
        ld_credits  = NUM_BUFS;
        ld_pulses   = 0;
        res_granted = RES_CREDITS;
        received    = 0;
        job_idx     = 0;
        word_idx    = 0;
        gap         = 0;
        job_sum     = 0;
        for (int t = 0; t < 64; t++) begin
            exp_valid[t] = 1'b0;
            seen[t]      = 1'b0;
        end

        repeat (5) begin
            @(posedge Clock);
            @(negedge Clock);
            check_idle("during reset");
        end
        rst = 1'b0;
        @(negedge Clock);
        check_idle("in the first cycle after reset");

        while (received < NUM_JOBS && !timed_out) begin
            step();
        end
        // Let the last load credits come back
        repeat (8) begin
            if (!timed_out) begin
                step();
            end
        end

        if (timed_out) begin
            errors++;
            $display("Timeout after %0d cycles with %0d of %0d results received",
                     cycle, received, NUM_JOBS);
        end
        for (int t = 0; t < NUM_JOBS; t++) begin
            if (!seen[t]) begin
                errors++;
                $display("Tag %0d was never received", t);
            end
        end
        if (ld_credits != NUM_BUFS || ld_pulses != NUM_JOBS) begin
            errors++;
            $display("Load credits end at %0d after %0d returns, expected %0d after %0d",
                     ld_credits, ld_pulses, NUM_BUFS, NUM_JOBS);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
source/accel_core_pkg.sv
source/accel_ifs.sv
source/job_buffer_bank.sv
source/mul_controller.sv
source/mac_unit.sv
source/result_sender.sv
source/accel_core_top.sv
test/accel_core_tb.sv

// ==== Makefile ====
SRCS := $(shell cat sim.f)

.PHONY: all run clean

all: obj_dir/Vaccel_core_tb

obj_dir/Vaccel_core_tb: sim.f $(SRCS)
	verilator --binary -j 0 --top-module accel_core_tb -f sim.f -o Vaccel_core_tb

run: obj_dir/Vaccel_core_tb
	@out="$$(./obj_dir/Vaccel_core_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
